// ==== rtl/soc_pkg.sv ====
package soc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus word types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address map, top is exclusive
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam word_t bram_base_addr  = 32'h0000_0000;
  localparam word_t bram_top_addr   = 32'h0000_1000;

  localparam word_t clint_base_addr = 32'h0200_0000;
  localparam word_t clint_top_addr  = 32'h0201_0000;

  localparam word_t uart_base_addr  = 32'h1000_0000;
  localparam word_t uart_top_addr   = 32'h1000_0100;

  // 4 KiB of 32-bit words
  localparam int bram_words = 1024;

  // target of the current request
  typedef enum logic [1:0] {
    sel_none,
    sel_bram,
    sel_uart,
    sel_clint
  } slave_sel_t;

endpackage

// ==== rtl/periph_pkg.sv ====
package periph_pkg;

  // low byte of the region-relative address
  typedef logic [7:0] reg_off_t;

  // uart registers
  localparam reg_off_t uart_txdata_off = 8'h00;
  localparam reg_off_t uart_status_off = 8'h04;
  localparam reg_off_t uart_rxdata_off = 8'h08;

  localparam int uart_tx_busy_bit  = 0;
  localparam int uart_rx_valid_bit = 1;

  // clint registers
  localparam reg_off_t clint_msip_off        = 8'h00;
  localparam reg_off_t clint_mtimecmp_lo_off = 8'h08;
  localparam reg_off_t clint_mtimecmp_hi_off = 8'h0C;
  localparam reg_off_t clint_mtime_lo_off    = 8'h10;
  localparam reg_off_t clint_mtime_hi_off    = 8'h14;

  // bit timing
  localparam int uart_clks_per_bit = 16;
  localparam int uart_cnt_w        = $clog2(uart_clks_per_bit);
  localparam logic [uart_cnt_w-1:0] uart_cnt_last = uart_cnt_w'(uart_clks_per_bit - 1);
  localparam logic [uart_cnt_w-1:0] uart_cnt_half = uart_cnt_w'(uart_clks_per_bit / 2 - 1);

  typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_t;

endpackage

// ==== rtl/mem_bus_if.sv ====
interface mem_bus_if import soc_pkg::*; ();

  logic  valid;
  logic  instr;
  word_t addr;
  word_t wdata;
  strb_t wstrb;
  word_t rdata;
  logic  ready;

  modport master (
    output valid, instr, addr, wdata, wstrb,
    input  rdata, ready
  );

  modport slave (
    input  valid, instr, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

// ==== rtl/bus_decoder.sv ====
module bus_decoder import soc_pkg::*; (
  input logic       clock,
  input logic       arst_n,
  mem_bus_if.slave  cpu,
  mem_bus_if.master bram_bus,
  mem_bus_if.master uart_bus,
  mem_bus_if.master clint_bus
);

  slave_sel_t sel;
  word_t      base_addr;
  word_t      local_addr;
  logic       unmapped_ready;

  function automatic logic in_region(word_t addr, word_t base, word_t top);
    return (addr >= base) && (addr < top);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    sel       = sel_none;
    base_addr = '0;
    if (in_region(cpu.addr, clint_base_addr, clint_top_addr)) begin
      sel       = sel_clint;
      base_addr = clint_base_addr;
    end else if (in_region(cpu.addr, uart_base_addr, uart_top_addr)) begin
      sel       = sel_uart;
      base_addr = uart_base_addr;
    end else if (in_region(cpu.addr, bram_base_addr, bram_top_addr)) begin
      sel       = sel_bram;
      base_addr = bram_base_addr;
    end
  end

  assign local_addr = cpu.addr - base_addr;

  assign bram_bus.valid  = cpu.valid && (sel == sel_bram);
  assign uart_bus.valid  = cpu.valid && (sel == sel_uart);
  assign clint_bus.valid = cpu.valid && (sel == sel_clint);

  // request fields fan out to every slave
  assign bram_bus.instr  = cpu.instr;
  assign bram_bus.addr   = local_addr;
  assign bram_bus.wdata  = cpu.wdata;
  assign bram_bus.wstrb  = cpu.wstrb;
  assign uart_bus.instr  = cpu.instr;
  assign uart_bus.addr   = local_addr;
  assign uart_bus.wdata  = cpu.wdata;
  assign uart_bus.wstrb  = cpu.wstrb;
  assign clint_bus.instr = cpu.instr;
  assign clint_bus.addr  = local_addr;
  assign clint_bus.wdata = cpu.wdata;
  assign clint_bus.wstrb = cpu.wstrb;

  // one late ready for each unmapped request
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      unmapped_ready <= 1'b0;
    end else begin
      unmapped_ready <= cpu.valid && (sel == sel_none) && !unmapped_ready;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (sel)
      sel_bram: begin
        cpu.rdata = bram_bus.rdata;
        cpu.ready = bram_bus.ready;
      end
      sel_uart: begin
        cpu.rdata = uart_bus.rdata;
        cpu.ready = uart_bus.ready;
      end
      sel_clint: begin
        cpu.rdata = clint_bus.rdata;
        cpu.ready = clint_bus.ready;
      end
      default: begin
        cpu.rdata = '0;
        cpu.ready = unmapped_ready;
      end
    endcase
  end

  // upstream ready stays a one-cycle pulse
  a_ready_pulse: assert property (@(posedge clock) disable iff (!arst_n)
    cpu.ready |=> !cpu.ready);

endmodule

// ==== rtl/bram.sv ====
module bram import soc_pkg::*; (
  input logic      clock,
  input logic      arst_n,
  mem_bus_if.slave bus
);

  word_t mem [bram_words];

  logic [$clog2(bram_words)-1:0] word_addr;
  word_t rdata_q;
  logic  ready_q;
  logic  access;

  assign word_addr = bus.addr[$clog2(bram_words)+1:2];

  // the request is still held while ready is high
  assign access = bus.valid && !ready_q;

  always_ff @(posedge clock) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wstrb[i]) begin
          mem[word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      rdata_q <= mem[word_addr];
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;

  // the word index covers the whole local address
  a_addr_in_range: assert property (@(posedge clock) disable iff (!arst_n)
    bus.valid |-> bus.addr[31:$clog2(bram_words)+2] == '0);

endmodule

// ==== rtl/uart.sv ====
module uart import soc_pkg::*, periph_pkg::*; (
  input  logic     clock,
  input  logic     arst_n,
  mem_bus_if.slave bus,
  input  logic     rx,
  output logic     tx
);

  reg_off_t off;
  logic     wr_req;
  logic     tx_busy;
  logic     access;
  logic     tx_load;
  logic     rx_clear;
  logic     ready_q;
  word_t    rdata_q;

  uart_state_t           tx_state;
  logic [uart_cnt_w-1:0] tx_cnt;
  logic [2:0]            tx_bit;
  logic [7:0]            tx_shift;

  uart_state_t           rx_state;
  logic [uart_cnt_w-1:0] rx_cnt;
  logic [2:0]            rx_bit;
  logic [7:0]            rx_shift;
  logic [7:0]            rx_data;
  logic                  rx_valid;
  logic                  rx_meta;
  logic                  rx_s;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register block
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign off     = bus.addr[7:0];
  assign wr_req  = bus.wstrb != '0;
  assign tx_busy = tx_state != uart_idle;

  // txdata writes wait here while a frame is on the line
  assign access   = bus.valid && !ready_q && !(wr_req && off == uart_txdata_off && tx_busy);
  assign tx_load  = access && wr_req && (off == uart_txdata_off);
  assign rx_clear = access && !wr_req && (off == uart_rxdata_off);

  always_ff @(posedge clock) begin
    if (access) begin
      rdata_q <= '0;
      if (off == uart_status_off) begin
        rdata_q[uart_tx_busy_bit]  <= tx_busy;
        rdata_q[uart_rx_valid_bit] <= rx_valid;
      end else if (off == uart_rxdata_off) begin
        rdata_q[7:0] <= rx_data;
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lsb-first transmitter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= uart_idle;
      tx_cnt   <= '0;
      tx_bit   <= '0;
    end else if (tx_state == uart_idle) begin
      tx_cnt <= '0;
      tx_bit <= '0;
      if (tx_load) begin
        tx_state <= uart_start;
      end
    end else if (tx_cnt != uart_cnt_last) begin
      tx_cnt <= tx_cnt + 1'b1;
    end else begin
      tx_cnt <= '0;
      case (tx_state)
        uart_start: tx_state <= uart_data;
        uart_data: begin
          tx_bit <= tx_bit + 1'b1;
          if (tx_bit == 3'd7) begin
            tx_state <= uart_stop;
          end
        end
        default: tx_state <= uart_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (tx_load) begin
      tx_shift <= bus.wdata[7:0];
    end else if (tx_state == uart_data && tx_cnt == uart_cnt_last) begin
      tx_shift <= {1'b1, tx_shift[7:1]};
    end
  end

  always_comb begin
    case (tx_state)
      uart_start: tx = 1'b0;
      uart_data:  tx = tx_shift[0];
      default:    tx = 1'b1;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receiver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta  <= 1'b1;
      rx_s     <= 1'b1;
      rx_state <= uart_idle;
      rx_cnt   <= '0;
      rx_bit   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      if (rx_clear) begin
        rx_valid <= 1'b0;
      end
      case (rx_state)
        uart_idle: begin
          rx_cnt <= '0;
          rx_bit <= '0;
          if (!rx_s) begin
            rx_state <= uart_start;
          end
        end
        uart_start: begin
          rx_cnt <= rx_cnt + 1'b1;
          // a glitch at mid start bit sends us back
          if (rx_cnt == uart_cnt_half) begin
            rx_cnt   <= '0;
            rx_state <= rx_s ? uart_idle : uart_data;
          end
        end
        uart_data: begin
          rx_cnt <= rx_cnt + 1'b1;
          if (rx_cnt == uart_cnt_last) begin
            rx_bit <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) begin
              rx_state <= uart_stop;
            end
          end
        end
        default: begin
          rx_cnt <= rx_cnt + 1'b1;
          if (rx_cnt == uart_cnt_last) begin
            rx_state <= uart_idle;
            if (rx_s) begin
              rx_valid <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (rx_state == uart_data && rx_cnt == uart_cnt_last) begin
      rx_shift <= {rx_s, rx_shift[7:1]};
    end
    if (rx_state == uart_stop && rx_cnt == uart_cnt_last && rx_s) begin
      rx_data <= rx_shift;
    end
  end

  // a held-off txdata write stays on the bus until ready
  a_tx_write_held: assert property (@(posedge clock) disable iff (!arst_n)
    bus.valid && wr_req && (off == uart_txdata_off) && !bus.ready
    |=> bus.ready || (bus.valid && $stable(bus.wdata)));

endmodule

// ==== rtl/clint.sv ====
module clint import soc_pkg::*, periph_pkg::*; (
  input  logic     clock,
  input  logic     arst_n,
  mem_bus_if.slave bus,
  output logic     msip,
  output logic     mtip
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  reg_off_t    off;
  logic        access;
  logic        wr;
  logic        ready_q;
  word_t       rdata_q;

  function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
    word_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign off    = bus.addr[7:0];
  assign access = bus.valid && !ready_q;
  assign wr     = access && (bus.wstrb != '0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime    <= '0;
      mtimecmp <= '1;
      msip     <= 1'b0;
      mtip     <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      mtime   <= mtime + 64'd1;
      mtip    <= mtime >= mtimecmp;
      ready_q <= access;
      if (wr) begin
        case (off)
          clint_msip_off: begin
            if (bus.wstrb[0]) begin
              msip <= bus.wdata[0];
            end
          end
          clint_mtimecmp_lo_off:
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], bus.wdata, bus.wstrb);
          clint_mtimecmp_hi_off:
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], bus.wdata, bus.wstrb);
          default: ;
        endcase
      end
    end
  end

  // mtime reads as seen at the sampling edge
  always_ff @(posedge clock) begin
    if (access) begin
      case (off)
        clint_msip_off:        rdata_q <= {31'b0, msip};
        clint_mtimecmp_lo_off: rdata_q <= mtimecmp[31:0];
        clint_mtimecmp_hi_off: rdata_q <= mtimecmp[63:32];
        clint_mtime_lo_off:    rdata_q <= mtime[31:0];
        clint_mtime_hi_off:    rdata_q <= mtime[63:32];
        default:               rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;

  // registers are reached by word accesses only
  a_word_aligned: assert property (@(posedge clock) disable iff (!arst_n)
    bus.valid |-> bus.addr[1:0] == 2'b00);

endmodule

// ==== rtl/soc.sv ====
module soc import soc_pkg::*; (
  input  logic  clock,
  input  logic  arst_n,
  input  logic  mem_valid,
  input  logic  mem_instr,
  input  word_t mem_addr,
  input  word_t mem_wdata,
  input  strb_t mem_wstrb,
  output word_t mem_rdata,
  output logic  mem_ready,
  input  logic  rx,
  output logic  tx,
  output logic  msip,
  output logic  mtip
);

  mem_bus_if cpu_bus ();
  mem_bus_if bram_bus ();
  mem_bus_if uart_bus ();
  mem_bus_if clint_bus ();

  // cpu side of the fabric
  assign cpu_bus.valid = mem_valid;
  assign cpu_bus.instr = mem_instr;
  assign cpu_bus.addr  = mem_addr;
  assign cpu_bus.wdata = mem_wdata;
  assign cpu_bus.wstrb = mem_wstrb;
  assign mem_rdata     = cpu_bus.rdata;
  assign mem_ready     = cpu_bus.ready;

  bus_decoder i_bus_decoder (
    .clock     (clock),
    .arst_n    (arst_n),
    .cpu       (cpu_bus.slave),
    .bram_bus  (bram_bus.master),
    .uart_bus  (uart_bus.master),
    .clint_bus (clint_bus.master)
  );

  bram i_bram (
    .clock  (clock),
    .arst_n (arst_n),
    .bus    (bram_bus.slave)
  );

  uart i_uart (
    .clock  (clock),
    .arst_n (arst_n),
    .bus    (uart_bus.slave),
    .rx     (rx),
    .tx     (tx)
  );

  clint i_clint (
    .clock  (clock),
    .arst_n (arst_n),
    .bus    (clint_bus.slave),
    .msip   (msip),
    .mtip   (mtip)
  );

endmodule

// ==== verif/soc_tb.sv ====
module soc_tb import soc_pkg::*, periph_pkg::*; ();

  localparam int    half_period   = 10;
  localparam int    reset_cycles  = 8;
  localparam int    bus_timeout   = 400;
  localparam int    uart_timeout  = 400;
  localparam int    poll_limit    = 200;
  localparam int    mtip_timeout  = 200;
  localparam int    bram_checks   = 16;
  localparam word_t unmapped_addr = 32'h3000_0000;

  logic  clock;
  logic  arst_n;
  logic  mem_valid;
  logic  mem_instr;
  word_t mem_addr;
  word_t mem_wdata;
  strb_t mem_wstrb;
  word_t mem_rdata;
  logic  mem_ready;
  logic  rx;
  logic  tx;
  logic  msip;
  logic  mtip;

  word_t bram_model [bram_words];
  word_t bram_addrs [bram_checks];
  word_t rng_state = 32'd89399;

  soc i_soc (
    .clock     (clock),
    .arst_n    (arst_n),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .rx        (rx),
    .tx        (tx),
    .msip      (msip),
    .mtip      (mtip)
  );

  always #half_period clock = ~clock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking and stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_with_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // xorshift32
  function automatic word_t next_rand();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic bus_transfer(input word_t addr, input word_t wdata, input strb_t wstrb,
                              output word_t rdata, output int cycles);
    logic got;
    @(negedge clock);
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < bus_timeout) begin
      @(negedge clock);
      cycles++;
      got = mem_ready;
    end
    if (!got) begin
      $display("bus request to 0x%08h was never answered", addr);
      stop_with_failure();
    end
    rdata     = mem_rdata;
    mem_valid = 1'b0;
    mem_wstrb = '0;
  endtask

  task automatic bus_write(input word_t addr, input word_t data, input strb_t strb);
    word_t unused;
    int    cycles;
    bus_transfer(addr, data, strb, unused, cycles);
  endtask

  task automatic bus_read(input word_t addr, output word_t data);
    int cycles;
    bus_transfer(addr, '0, '0, data, cycles);
  endtask

  task automatic uart_send(input logic [7:0] b);
    @(negedge clock);
    rx = 1'b0;
    repeat (uart_clks_per_bit) @(negedge clock);
    for (int i = 0; i < 8; i++) begin
      rx = b[i];
      repeat (uart_clks_per_bit) @(negedge clock);
    end
    rx = 1'b1;
    repeat (uart_clks_per_bit) @(negedge clock);
  endtask

  task automatic uart_capture(output logic [7:0] b);
    int waited;
    waited = 0;
    while (tx !== 1'b0 && waited < uart_timeout) begin
      @(negedge clock);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("no start bit appeared on tx");
      stop_with_failure();
    end
    // first low sample is half a cycle into the start bit
    repeat (uart_clks_per_bit / 2 - 1) @(negedge clock);
    check_bit("tx start bit", tx, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (uart_clks_per_bit) @(negedge clock);
      b[i] = tx;
    end
    repeat (uart_clks_per_bit) @(negedge clock);
    check_bit("tx stop bit", tx, 1'b1);
  endtask

  task automatic wait_tx_idle();
    word_t status;
    int    tries;
    tries  = 0;
    status = '1;
    while (status[uart_tx_busy_bit] && tries < poll_limit) begin
      bus_read(uart_base_addr + uart_status_off, status);
      tries++;
    end
    if (status[uart_tx_busy_bit]) begin
      $display("uart transmitter never went idle");
      stop_with_failure();
    end
  endtask

  // byte lanes land one by one under the strobe
  function automatic void model_store(word_t addr, word_t data, strb_t strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        bram_model[addr[$clog2(bram_words)+1:2]][8*i +: 8] = data[8*i +: 8];
      end
    end
  endfunction

  task automatic compare_bram_contents();
    word_t got;
    for (int i = 0; i < bram_checks; i++) begin
      bus_read(bram_addrs[i], got);
      check_word($sformatf("bram[0x%03h]", bram_addrs[i]), got,
                 bram_model[bram_addrs[i][$clog2(bram_words)+1:2]]);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic bram_round_trip();
    word_t r;
    word_t data;
    strb_t strb;
    int    idx;
    for (int i = 0; i < bram_checks; i++) begin
      r = next_rand();
      bram_addrs[i] = (i == 0) ? 32'h0 : (r & 32'h0000_0ffc);
      data = next_rand();
      bus_write(bram_addrs[i], data, 4'hf);
      model_store(bram_addrs[i], data, 4'hf);
    end
    for (int n = 0; n < 24; n++) begin
      r    = next_rand();
      idx  = int'(r[3:0]);
      strb = (r[7:4] == 4'h0) ? 4'h5 : r[7:4];
      data = next_rand();
      bus_write(bram_addrs[idx], data, strb);
      model_store(bram_addrs[idx], data, strb);
    end
    compare_bram_contents();
  endtask

  task automatic unmapped_access();
    word_t got;
    for (int i = 0; i < 4; i++) begin
      bus_read(unmapped_addr + 4 * i, got);
      check_word("unmapped rdata", got, 32'h0);
    end
    bus_write(unmapped_addr, next_rand(), 4'hf);
    compare_bram_contents();
  endtask

  task automatic uart_tx_frame();
    word_t      r;
    word_t      status;
    logic [7:0] sent;
    logic [7:0] seen;
    r    = next_rand();
    sent = r[7:0];
    fork
      uart_capture(seen);
      begin
        bus_write(uart_base_addr + uart_txdata_off, {24'h0, sent}, 4'h1);
        bus_read(uart_base_addr + uart_status_off, status);
        check_bit("status.tx_busy", status[uart_tx_busy_bit], 1'b1);
      end
    join
    check_word("tx byte", {24'h0, seen}, {24'h0, sent});
    wait_tx_idle();
  endtask

  task automatic uart_back_pressure();
    word_t      r;
    word_t      status;
    word_t      unused;
    logic [7:0] first;
    logic [7:0] second;
    logic [7:0] seen0;
    logic [7:0] seen1;
    int         cycles;
    int         captured;
    r        = next_rand();
    first    = r[7:0];
    second   = r[15:8];
    captured = 0;
    fork
      begin
        uart_capture(seen0);
        captured = 1;
        uart_capture(seen1);
      end
      begin
        bus_write(uart_base_addr + uart_txdata_off, {24'h0, first}, 4'h1);
        bus_read(uart_base_addr + uart_status_off, status);
        check_bit("status.tx_busy", status[uart_tx_busy_bit], 1'b1);
        // held until the first frame has left the line
        bus_transfer(uart_base_addr + uart_txdata_off, {24'h0, second}, 4'h1,
                     unused, cycles);
        check_bit("txdata write held off", cycles > 9 * uart_clks_per_bit, 1'b1);
        check_bit("first frame done before second ready", captured == 1, 1'b1);
      end
    join
    check_word("tx first byte", {24'h0, seen0}, {24'h0, first});
    check_word("tx second byte", {24'h0, seen1}, {24'h0, second});
    wait_tx_idle();
  endtask

  task automatic uart_rx_frame();
    word_t      r;
    word_t      status;
    word_t      data;
    logic [7:0] sent;
    int         tries;
    r    = next_rand();
    sent = r[7:0];
    uart_send(sent);
    tries  = 0;
    status = '0;
    while (!status[uart_rx_valid_bit] && tries < poll_limit) begin
      bus_read(uart_base_addr + uart_status_off, status);
      tries++;
    end
    if (!status[uart_rx_valid_bit]) begin
      $display("rx_valid never set after a frame on rx");
      stop_with_failure();
    end
    bus_read(uart_base_addr + uart_rxdata_off, data);
    check_word("rxdata", data, {24'h0, sent});
    bus_read(uart_base_addr + uart_status_off, status);
    check_bit("status.rx_valid", status[uart_rx_valid_bit], 1'b0);
  endtask

  task automatic clint_timer();
    word_t       lo;
    word_t       hi;
    logic [63:0] target;
    int          waited;
    bus_read(clint_base_addr + clint_mtimecmp_lo_off, lo);
    bus_read(clint_base_addr + clint_mtimecmp_hi_off, hi);
    check_word("mtimecmp lo", lo, 32'hffff_ffff);
    check_word("mtimecmp hi", hi, 32'hffff_ffff);
    bus_write(clint_base_addr + clint_msip_off, 32'h1, 4'hf);
    check_bit("msip", msip, 1'b1);
    bus_write(clint_base_addr + clint_msip_off, 32'h0, 4'hf);
    check_bit("msip", msip, 1'b0);
    bus_write(clint_base_addr + clint_mtimecmp_lo_off, 32'hffff_ffff, 4'hf);
    bus_write(clint_base_addr + clint_mtimecmp_hi_off, 32'hffff_ffff, 4'hf);
    @(negedge clock);
    check_bit("mtip", mtip, 1'b0);
    bus_read(clint_base_addr + clint_mtime_lo_off, lo);
    bus_read(clint_base_addr + clint_mtime_hi_off, hi);
    target = {hi, lo} + 64'd50;
    // low half first, the high half stays all ones meanwhile
    bus_write(clint_base_addr + clint_mtimecmp_lo_off, target[31:0], 4'hf);
    bus_write(clint_base_addr + clint_mtimecmp_hi_off, target[63:32], 4'hf);
    check_bit("mtip", mtip, 1'b0);
    waited = 0;
    while (!mtip && waited < mtip_timeout) begin
      @(negedge clock);
      waited++;
    end
    if (!mtip) begin
      $display("mtip never rose after mtimecmp was set");
      stop_with_failure();
    end
    bus_read(clint_base_addr + clint_mtime_lo_off, lo);
    bus_read(clint_base_addr + clint_mtime_hi_off, hi);
    check_bit("mtime reached mtimecmp", {hi, lo} >= target, 1'b1);
  endtask

  initial begin
    clock     = 1'b0;
    arst_n    = 1'b0;
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    rx        = 1'b1;
    repeat (reset_cycles) @(negedge clock);
    arst_n = 1'b1;
    check_bit("mem_ready", mem_ready, 1'b0);
    check_bit("tx", tx, 1'b1);
    check_bit("msip", msip, 1'b0);
    check_bit("mtip", mtip, 1'b0);
    bram_round_trip();
    unmapped_access();
    uart_tx_frame();
    uart_back_pressure();
    uart_rx_frame();
    clint_timer();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== src.f ====
rtl/soc_pkg.sv
rtl/periph_pkg.sv
rtl/mem_bus_if.sv
rtl/bus_decoder.sv
rtl/bram.sv
rtl/uart.sv
rtl/clint.sv
rtl/soc.sv
verif/soc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = soc_tb
FILELIST  = src.f
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
